// File: verilog/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Fetch address width
`define BP_PC_W 32

// Global history length, also log2 of the counter table size
`define BP_GHR_W 4
`define BP_PHT_DEPTH (1 << `BP_GHR_W)

// Tagged tables, index from PC[5:2], tag from PC[31:6]
`define BP_TBL_IDX_W 4
`define BP_TBL_DEPTH (1 << `BP_TBL_IDX_W)
`define BP_PC_LSB 2
`define BP_TAG_LSB (`BP_PC_LSB + `BP_TBL_IDX_W)
`define BP_TAG_W (`BP_PC_W - `BP_TAG_LSB)

// Sequential fetch step and fetch address after reset
`define BP_PC_STEP 32'd4
`define BP_RESET_PC 32'h0000_0000

`endif

// File: verilog/bp_fetch_pkg.sv
`include "bp_consts.svh"

// Address-side types of the fetch predictor
package bp_fetch_pkg;

    // Fetch or resolve address
    typedef logic [`BP_PC_W-1:0] pc_t;

    // Target buffer entry payload
    // Only the taken target is kept, the tag lives in the table itself
    typedef struct packed {
        pc_t target;
    } target_t;

    // Byte offset of a 32-bit instruction word
    localparam int unsigned PC_ALIGN_BITS = `BP_PC_LSB;

    // Word-aligned check on a fetch address
    function automatic logic pc_aligned(input pc_t addr);
        return addr[PC_ALIGN_BITS-1:0] == '0;
    endfunction

endpackage

// File: verilog/bp_predict_pkg.sv
`include "bp_consts.svh"

// Direction-side types of the fetch predictor
package bp_predict_pkg;

    // Global history, newest outcome in bit 0
    typedef logic [`BP_GHR_W-1:0] ghr_t;

    // 2-bit saturating counter states
    typedef enum logic [1:0] {
        CTR_SNT = 2'b00,
        CTR_WNT = 2'b01,
        CTR_WT  = 2'b10,
        CTR_ST  = 2'b11
    } ctr_t;

    // Counter state after reset
    localparam ctr_t CTR_RESET = CTR_WNT;

    // Recovery entry, direction predicted at fetch
    typedef struct packed {
        logic pred_taken;
    } recovery_t;

endpackage

// File: verilog/resolve_if.sv
`timescale 1ns/10ps

// One resolved control-flow event from execute
// Plain levels, valid for the cycle they are presented
interface resolve_if;

    import bp_fetch_pkg::*;

    // Conditional branch in execute
    logic branch;
    // Branch outcome
    logic taken;
    // Address of the resolving instruction
    pc_t  pc;
    // Computed branch or jump target
    pc_t  target;
    // Unconditional jump in execute
    logic jump;
    // Target buffer hit carried down the pipe with the instruction
    logic id_hit;

    // Driver side
    modport ctrl (
        output branch, taken, pc, target, jump, id_hit
    );

    // Counter table only needs the branch outcome
    modport pht (
        input branch, taken
    );

    // PC unit sees the whole event
    modport fetch (
        input branch, taken, pc, target, jump, id_hit
    );

endinterface

// File: verilog/pattern_history_table.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

// Global history register plus a table of 2-bit saturating counters
// Indexed by history alone
module pattern_history_table (
    input  logic          clk,
    input  logic          rst_n,
    resolve_if.pht        rsv,
    output logic          taken
);

    import bp_predict_pkg::*;

    // History register
    ghr_t ghr_q;

    // Counter array
    ctr_t ctr_q [`BP_PHT_DEPTH];

    // Counter under the current history
    ctr_t ctr_cur;

    // Counter value after the resolved outcome
    ctr_t ctr_upd;

    // One step toward the outcome, clamped at both ends
    function automatic ctr_t ctr_step(input ctr_t cur, input logic up);
        ctr_t nxt;
        nxt = cur;
        case (cur)
            CTR_SNT: nxt = up ? CTR_WNT : CTR_SNT;
            CTR_WNT: nxt = up ? CTR_WT  : CTR_SNT;
            CTR_WT:  nxt = up ? CTR_ST  : CTR_WNT;
            CTR_ST:  nxt = up ? CTR_ST  : CTR_WT;
            default: nxt = CTR_RESET;
        endcase
        return nxt;
    endfunction

    assign ctr_cur = ctr_q[ghr_q];
    assign ctr_upd = ctr_step(ctr_cur, rsv.taken);

    // Weak-taken or stronger predicts taken
    assign taken = (ctr_cur == CTR_WT) || (ctr_cur == CTR_ST);

    // Counter update uses the pre-shift history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (rsv.branch) begin
            ctr_q[ghr_q] <= ctr_upd;
        end
    end

    // Shift in the outcome on every resolved branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (rsv.branch) begin
            ghr_q <= {ghr_q[`BP_GHR_W-2:0], rsv.taken};
        end
    end

endmodule

// File: verilog/tagged_table.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

// Direct-mapped tagged table with a valid bit per entry
// Read and write use separate addresses
module tagged_table #(
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  logic               rst_n,
    // Lookup port
    input  bp_fetch_pkg::pc_t  rd_pc,
    output logic               rd_hit,
    output payload_t           rd_data,
    // Update port
    input  logic               wr_en,
    input  bp_fetch_pkg::pc_t  wr_pc,
    input  payload_t           wr_data
);

    localparam int IDX_W = `BP_TBL_IDX_W;
    localparam int TAG_W = `BP_TAG_W;

    // Entry storage
    logic             valid_q [`BP_TBL_DEPTH];
    logic [TAG_W-1:0] tag_q   [`BP_TBL_DEPTH];
    payload_t         data_q  [`BP_TBL_DEPTH];

    // Address split for both ports
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = rd_pc[`BP_TAG_LSB-1:`BP_PC_LSB];
    assign rd_tag = rd_pc[`BP_PC_W-1:`BP_TAG_LSB];
    assign wr_idx = wr_pc[`BP_TAG_LSB-1:`BP_PC_LSB];
    assign wr_tag = wr_pc[`BP_PC_W-1:`BP_TAG_LSB];

    // Combinational lookup
    // Same-cycle write is not forwarded, old entry is returned
    assign rd_hit  = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rd_data = data_q[rd_idx];

    // Valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BP_TBL_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and payload, whole entry replaced on write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= wr_data;
        end
    end

endmodule

// File: verilog/fetch_pc_unit.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

// Fetch PC register and next-PC selection
module fetch_pc_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    resolve_if.fetch                  rsv,
    // Target buffer lookup at the current PC
    input  logic                      btb_hit,
    input  bp_fetch_pkg::target_t     btb_target,
    // Direction from the counter table
    input  logic                      pred_taken,
    // Recovery lookup at the resolve PC
    input  logic                      rec_hit,
    input  bp_predict_pkg::recovery_t rec_data,
    output bp_fetch_pkg::pc_t         pc,
    output logic                      mispredict,
    output logic                      redirect,
    output logic                      btb_wr_en
);

    import bp_fetch_pkg::*;

    pc_t pc_seq;
    pc_t pc_fix;
    pc_t pc_next;

    // Jump, or a taken branch the target buffer missed at fetch
    assign redirect = rsv.jump || (rsv.branch && rsv.taken && !rsv.id_hit);

    // Recorded direction disagrees with the outcome
    assign mispredict = rsv.branch && rec_hit && (rec_data.pred_taken != rsv.taken);

    // Install targets of taken branches
    assign btb_wr_en = rsv.branch && rsv.taken;

    assign pc_seq = pc + `BP_PC_STEP;

    // Correction path, target or fall-through of the resolving branch
    assign pc_fix = rsv.taken ? rsv.target : rsv.pc + `BP_PC_STEP;

    // Priority: redirect, mispredict, predicted taken, sequential
    always_comb begin
        if (redirect) begin
            pc_next = rsv.target;
        end else if (mispredict) begin
            pc_next = pc_fix;
        end else if (btb_hit && pred_taken) begin
            pc_next = btb_target.target;
        end else begin
            pc_next = pc_seq;
        end
    end

    // PC register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `BP_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: verilog/branch_predictor_top.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

// Fetch-side global branch predictor
module branch_predictor_top (
    input  logic                clk,
    input  logic                rst_n,
    // Resolve event from execute
    input  logic                id_ex_branch,
    input  logic                pcsrc,
    input  logic [`BP_PC_W-1:0] id_ex_pc,
    input  logic [`BP_PC_W-1:0] pc_branch,
    input  logic                id_ex_jump,
    input  logic                id_ex_hit,
    // Fetch side
    output logic [`BP_PC_W-1:0] pc,
    output logic                wrong,
    output logic                first_and_pcsrc,
    output logic                hit,
    output logic                taken
);

    import bp_fetch_pkg::*;
    import bp_predict_pkg::*;

    // Target buffer read data
    target_t   btb_target;
    // Recovery table read side
    logic      rec_hit;
    recovery_t rec_data;
    // Target buffer write strobe from the PC unit
    logic      btb_wr_en;

    // Resolve bundle
    resolve_if rsv ();

    assign rsv.branch = id_ex_branch;
    assign rsv.taken  = pcsrc;
    assign rsv.pc     = id_ex_pc;
    assign rsv.target = pc_branch;
    assign rsv.jump   = id_ex_jump;
    assign rsv.id_hit = id_ex_hit;

    // Direction prediction
    pattern_history_table i_pht (
        .clk   (clk),
        .rst_n (rst_n),
        .rsv   (rsv.pht),
        .taken (taken)
    );

    // Target buffer
    // Looked up at fetch, filled by taken branches at resolve
    tagged_table #(
        .payload_t (target_t)
    ) i_btb (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_pc   (pc),
        .rd_hit  (hit),
        .rd_data (btb_target),
        .wr_en   (btb_wr_en),
        .wr_pc   (id_ex_pc),
        .wr_data (pc_branch)
    );

    // Recovery table
    // Records the fetch-time direction of every target buffer hit
    tagged_table #(
        .payload_t (recovery_t)
    ) i_rec (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_pc   (id_ex_pc),
        .rd_hit  (rec_hit),
        .rd_data (rec_data),
        .wr_en   (hit),
        .wr_pc   (pc),
        .wr_data (taken)
    );

    // Fetch PC and next-PC selection
    fetch_pc_unit i_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsv        (rsv.fetch),
        .btb_hit    (hit),
        .btb_target (btb_target),
        .pred_taken (taken),
        .rec_hit    (rec_hit),
        .rec_data   (rec_data),
        .pc         (pc),
        .mispredict (wrong),
        .redirect   (first_and_pcsrc),
        .btb_wr_en  (btb_wr_en)
    );

endmodule

// File: dv/bp_fetch_chk.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

// Assertions on the fetch PC unit
module bp_fetch_chk (
    input logic              clk,
    input logic              rst_n,
    input bp_fetch_pkg::pc_t pc,
    input logic              mispredict,
    input logic              redirect,
    // Resolve event fields
    input logic              taken,
    input bp_fetch_pkg::pc_t res_pc,
    input bp_fetch_pkg::pc_t target
);

    import bp_fetch_pkg::*;

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Fetch stays on instruction words
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc_aligned(pc))
        else begin
            $error("fetch pc %h is not word-aligned", pc);
            fail_count++;
        end

    // Misprediction steers fetch to the corrected path unless a redirect wins
    a_mispredict_fix: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict && !redirect |=>
            pc == ($past(taken) ? $past(target) : $past(res_pc) + 32'd4))
        else begin
            $error("pc %h after mispredict differs from the corrected path", pc);
            fail_count++;
        end

    // Redirect wins over every other next-PC source
    a_redirect_target: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> pc == $past(target))
        else begin
            $error("pc %h after redirect differs from resolve target", pc);
            fail_count++;
        end

    // First cycle out of reset fetches from the reset address
    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == `BP_RESET_PC)
        else begin
            $error("pc %h after reset differs from the reset address", pc);
            fail_count++;
        end

endmodule

// Attach to every fetch PC unit
bind fetch_pc_unit bp_fetch_chk i_fetch_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .mispredict (mispredict),
    .redirect   (redirect),
    .taken      (rsv.taken),
    .res_pc     (rsv.pc),
    .target     (rsv.target)
);

// File: dv/tb_branch_predictor.sv
`timescale 1ns/10ps
`include "bp_consts.svh"

module tb_branch_predictor;

    localparam int RESET_CYCLES = 4;
    localparam int N_DIRECTED   = 40;
    localparam int N_RANDOM     = 2000;
    // Stimulus length plus 10%
    localparam int CYCLE_LIMIT  = (RESET_CYCLES + N_DIRECTED + N_RANDOM) * 11 / 10;
    localparam int DEPTH        = `BP_TBL_DEPTH;

    logic                clk;
    logic                rst_n;
    logic                id_ex_branch;
    logic                pcsrc;
    logic [`BP_PC_W-1:0] id_ex_pc;
    logic [`BP_PC_W-1:0] pc_branch;
    logic                id_ex_jump;
    logic                id_ex_hit;
    logic [`BP_PC_W-1:0] pc;
    logic                wrong;
    logic                first_and_pcsrc;
    logic                hit;
    logic                taken;

    // Reference model state
    logic [`BP_GHR_W-1:0] m_ghr;
    int                   m_ctr [`BP_PHT_DEPTH];
    logic                 m_btb_valid [DEPTH];
    logic [`BP_TAG_W-1:0] m_btb_tag [DEPTH];
    logic [`BP_PC_W-1:0]  m_btb_tgt [DEPTH];
    logic                 m_rec_valid [DEPTH];
    logic [`BP_TAG_W-1:0] m_rec_tag [DEPTH];
    logic                 m_rec_pred [DEPTH];
    logic [`BP_PC_W-1:0]  m_pc;

    // Address pool, 0x10 and 0x50 alias at index 4
    logic [`BP_PC_W-1:0] pool [8];
    int errors;
    int checks;
    int cycle_count;

    branch_predictor_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_ex_branch    (id_ex_branch),
        .pcsrc           (pcsrc),
        .id_ex_pc        (id_ex_pc),
        .pc_branch       (pc_branch),
        .id_ex_jump      (id_ex_jump),
        .id_ex_hit       (id_ex_hit),
        .pc              (pc),
        .wrong           (wrong),
        .first_and_pcsrc (first_and_pcsrc),
        .hit             (hit),
        .taken           (taken)
    );

    always #50 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [`BP_TBL_IDX_W-1:0] idx_of(input logic [`BP_PC_W-1:0] a);
        return a[`BP_TAG_LSB-1:`BP_PC_LSB];
    endfunction

    function automatic logic [`BP_TAG_W-1:0] tag_of(input logic [`BP_PC_W-1:0] a);
        return a[`BP_PC_W-1:`BP_TAG_LSB];
    endfunction

    // Model target buffer hit for an address
    function automatic logic btb_lookup(input logic [`BP_PC_W-1:0] a);
        return m_btb_valid[idx_of(a)] && (m_btb_tag[idx_of(a)] == tag_of(a));
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // One cycle: drive after the edge, check mid-cycle, advance the model
    task automatic run_cycle(input logic br, input logic tk, input logic [`BP_PC_W-1:0] rpc,
                             input logic [`BP_PC_W-1:0] tgt, input logic jmp);
        logic                      exp_hit;
        logic                      exp_taken;
        logic                      exp_redirect;
        logic                      exp_wrong;
        logic                      rec_hit;
        logic [`BP_PC_W-1:0]       exp_next;
        logic [`BP_TBL_IDX_W-1:0]  ridx;
        logic [`BP_TBL_IDX_W-1:0]  fidx;
        id_ex_branch = br;
        pcsrc        = br && tk;
        id_ex_pc     = rpc;
        pc_branch    = tgt;
        id_ex_jump   = jmp;
        // Hit bit carried from fetch
        id_ex_hit    = btb_lookup(rpc);
        ridx = idx_of(rpc);
        fidx = idx_of(m_pc);
        exp_hit      = btb_lookup(m_pc);
        exp_taken    = m_ctr[m_ghr] >= 2;
        exp_redirect = jmp || (br && tk && !id_ex_hit);
        rec_hit      = m_rec_valid[ridx] && (m_rec_tag[ridx] == tag_of(rpc));
        exp_wrong    = br && rec_hit && (m_rec_pred[ridx] != tk);
        if (exp_redirect) begin
            exp_next = tgt;
        end else if (exp_wrong) begin
            exp_next = tk ? tgt : rpc + `BP_PC_STEP;
        end else if (exp_hit && exp_taken) begin
            exp_next = m_btb_tgt[fidx];
        end else begin
            exp_next = m_pc + `BP_PC_STEP;
        end
        @(negedge clk);
        compare("pc", m_pc, pc);
        compare("hit", {31'b0, exp_hit}, {31'b0, hit});
        compare("taken", {31'b0, exp_taken}, {31'b0, taken});
        compare("wrong", {31'b0, exp_wrong}, {31'b0, wrong});
        compare("first_and_pcsrc", {31'b0, exp_redirect}, {31'b0, first_and_pcsrc});
        // Counter at pre-shift history, then shift
        if (br) begin
            if (tk && m_ctr[m_ghr] < 3) begin
                m_ctr[m_ghr]++;
            end else if (!tk && m_ctr[m_ghr] > 0) begin
                m_ctr[m_ghr]--;
            end
            m_ghr = {m_ghr[`BP_GHR_W-2:0], tk};
        end
        if (br && tk) begin
            m_btb_valid[ridx] = 1'b1;
            m_btb_tag[ridx]   = tag_of(rpc);
            m_btb_tgt[ridx]   = tgt;
        end
        // Fetch-time direction of each buffer hit
        if (exp_hit) begin
            m_rec_valid[fidx] = 1'b1;
            m_rec_tag[fidx]   = tag_of(m_pc);
            m_rec_pred[fidx]  = exp_taken;
        end
        m_pc = exp_next;
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0]         rnd;
        int                  r;
        logic [`BP_PC_W-1:0] rpc;
        logic [`BP_PC_W-1:0] tgt;
        int unsigned         asrt_fails;
        void'($urandom(4263));
        errors = 0;
        checks = 0;
        cycle_count = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        id_ex_branch = 1'b0;
        pcsrc = 1'b0;
        id_ex_pc = '0;
        pc_branch = '0;
        id_ex_jump = 1'b0;
        id_ex_hit = 1'b0;
        pool = '{32'h00, 32'h08, 32'h10, 32'h1c, 32'h24, 32'h30, 32'h50, 32'h38};
        m_ghr = '0;
        m_pc = `BP_RESET_PC;
        for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
            m_ctr[i] = 1;
        end
        for (int i = 0; i < DEPTH; i++) begin
            m_btb_valid[i] = 1'b0;
            m_rec_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Sequential fetch out of reset
        repeat (6) run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        // Taken branches saturate counters up and install the target
        repeat (8) run_cycle(1'b1, 1'b1, 32'h10, 32'h40, 1'b0);
        // Fetch the installed branch, then its alias
        run_cycle(1'b0, 1'b0, 32'h08, 32'h10, 1'b1);
        repeat (4) run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        run_cycle(1'b0, 1'b0, 32'h08, 32'h50, 1'b1);
        repeat (4) run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        // Not-taken outcomes pull counters down, recovered ones mispredict
        repeat (8) run_cycle(1'b1, 1'b0, 32'h10, 32'h40, 1'b0);
        repeat (4) run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
        // Random mix, about 40% branches and 10% jumps
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $urandom;
            r = rnd % 100;
            rpc = pool[rnd[9:7]];
            tgt = pool[rnd[12:10]];
            if (r < 40) begin
                run_cycle(1'b1, rnd[16], rpc, tgt, 1'b0);
            end else if (r < 50) begin
                run_cycle(1'b0, 1'b0, rpc, tgt, 1'b1);
            end else begin
                run_cycle(1'b0, 1'b0, rpc, tgt, 1'b0);
            end
        end
        asrt_fails = i_dut.i_fetch.i_fetch_chk.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/bp_fetch_pkg.sv
verilog/bp_predict_pkg.sv
verilog/resolve_if.sv
verilog/pattern_history_table.sv
verilog/tagged_table.sv
verilog/fetch_pc_unit.sv
verilog/branch_predictor_top.sv
dv/bp_fetch_chk.sv
dv/tb_branch_predictor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_branch_predictor
BUILD_DIR=obj_dir
LOG=sim.log

# Compile RTL and testbench into one simulation binary
verilator --binary --timing --assert \
    -f src.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

# Run and keep the transcript
"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# The verdict comes from the log
if grep -q "^PASS: all tests$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi
